// File: all.f
+incdir+include
src/wiscIsaPkg.sv
src/wiscPipePkg.sv
src/instrIntake.sv
src/decodeStage.sv
src/idExLatch.sv
src/executeStage.sv
src/resultPort.sv
src/wiscIdExTop.sv
verif/tbWiscIdEx.sv

// File: Bender.yml
package:
  name: wisc_id_ex

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/wiscIsaPkg.sv
      - src/wiscPipePkg.sv
      - src/instrIntake.sv
      - src/decodeStage.sv
      - src/idExLatch.sv
      - src/executeStage.sv
      - src/resultPort.sv
      - src/wiscIdExTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tbWiscIdEx.sv

// File: verif/tbWiscIdEx.sv
`include "wiscPipe_cfg.svh"

module tbWiscIdEx;

  localparam int driveDelay = 10;
  // about 80 instructions at no more than 12 cycles each plus idle checks, with margin
  localparam int cycleLimit = 4000;
  localparam int expLatency = 2;  // edges after the ack edge: ID/EX load, then result capture

  logic                clk;
  logic                rstN;
  logic                wbCyc;
  logic                wbStb;
  logic                wbWe;
  logic                wbAck;
  wiscIsaPkg::word_t   wbDatIn;
  logic                resCyc;
  logic                resStb;
  logic                resWe;
  logic                resAck;
  wiscIsaPkg::regIdx_t resAdr;
  wiscIsaPkg::word_t   resDat;

  logic [31:0] lcgState = 32'h19378431;
  int cycleCount = 0;
  int errorCount = 0;
  int testCount = 0;
  int failedTests = 0;
  int ackDelayMax = 0;  // result bus acks after 0 to this many wait cycles

  wiscIsaPkg::word_t   modelRegs [`WISC_REG_COUNT];
  wiscIsaPkg::word_t   progQ [$];
  wiscIsaPkg::regIdx_t expAdr [$];
  wiscIsaPkg::word_t   expDat [$];
  wiscIsaPkg::regIdx_t gotAdr [$];
  wiscIsaPkg::word_t   gotDat [$];
  int ackCycles [$];
  int startCycles [$];

  wiscIdExTop i_dut (
    .clk, .rstN,
    .wbCyc, .wbStb, .wbWe, .wbDatIn, .wbAck,
    .resCyc, .resStb, .resWe, .resAdr, .resDat, .resAck
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("run stopped after %0d cycles without finishing the tests", cycleLimit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic wiscIsaPkg::word_t makeRType(input logic [1:0] func,
      input wiscIsaPkg::regIdx_t rd, input wiscIsaPkg::regIdx_t rs,
      input wiscIsaPkg::regIdx_t rt);
    return {`WISC_OP_RTYPE, rs, rt, rd, func};
  endfunction

  // ADDI and ANDNI write the rt-position field
  function automatic wiscIsaPkg::word_t makeImm(input logic [4:0] op,
      input wiscIsaPkg::regIdx_t dst, input wiscIsaPkg::regIdx_t src, input logic [4:0] imm);
    return {op, src, dst, imm};
  endfunction

  function automatic wiscIsaPkg::word_t makeLbi(input wiscIsaPkg::regIdx_t dst,
      input logic [7:0] imm);
    return {`WISC_OP_LBI, dst, imm};
  endfunction

  // reference register model, applied in program order
  function automatic void applyModel(input wiscIsaPkg::word_t instr);
    wiscIsaPkg::regIdx_t rs;
    wiscIsaPkg::regIdx_t rt;
    wiscIsaPkg::regIdx_t dest;
    wiscIsaPkg::word_t   a;
    wiscIsaPkg::word_t   b;
    wiscIsaPkg::word_t   value;
    logic                writes;
    rs     = instr[10:8];
    rt     = instr[7:5];
    a      = modelRegs[rs];
    b      = modelRegs[rt];
    dest   = rt;
    value  = '0;
    writes = 1'b1;
    case (instr[15:11])
      `WISC_OP_RTYPE: begin
        dest = instr[4:2];
        case (instr[1:0])
          `WISC_RFUNC_ADD: value = a + b;
          `WISC_RFUNC_SUB: value = b - a;
          `WISC_RFUNC_XOR: value = a ^ b;
          default:         value = a & ~b;
        endcase
      end
      `WISC_OP_ADDI:  value = a + {{11{instr[4]}}, instr[4:0]};
      `WISC_OP_ANDNI: value = a & ~{11'b0, instr[4:0]};
      `WISC_OP_LBI: begin
        dest  = rs;
        value = {{8{instr[7]}}, instr[7:0]};
      end
      default: writes = 1'b0;  // NOP and every unknown opcode
    endcase
    if (writes) begin
      modelRegs[dest] = value;
      expAdr.push_back(dest);
      expDat.push_back(value);
    end
  endfunction

  task automatic checkValue(input string sigName, input logic [15:0] expected,
      input logic [15:0] actual);
    assert (actual === expected) else begin
      errorCount++;
      $display("FAIL %0t %s: expected %h, got %h", $time, sigName, expected, actual);
    end
  endtask

  // result bus slave, samples and drives just after each rising edge
  initial begin : resultResponder
    int   waitLeft;
    logic inCycle;
    waitLeft = 0;
    inCycle  = 1'b0;
    forever begin
      @(posedge clk);
      #driveDelay;
      if (resAck) begin
        resAck  = 1'b0;  // the cycle ended on this edge
        inCycle = 1'b0;
      end else if (resStb) begin
        if (!inCycle) begin
          inCycle = 1'b1;
          startCycles.push_back(cycleCount);
          waitLeft = (ackDelayMax == 0) ? 0 : int'(lcgNext() >> 16) % (ackDelayMax + 1);
          assert (resCyc && resWe) else begin
            errorCount++;
            $display("result cycle at %0t has stb without cyc and we", $time);
          end
        end
        if (waitLeft == 0) begin
          resAck = 1'b1;
          gotAdr.push_back(resAdr);
          gotDat.push_back(resDat);
        end else begin
          waitLeft--;
        end
      end else begin
        assert (!inCycle) else begin
          errorCount++;
          inCycle = 1'b0;
          $display("resStb dropped before resAck at %0t", $time);
        end
      end
    end
  end

  task automatic clearQueues();
    progQ.delete();
    expAdr.delete();
    expDat.delete();
    gotAdr.delete();
    gotDat.delete();
    ackCycles.delete();
    startCycles.delete();
  endtask

  // keeps stb high from one instruction to the next so hazards can build up
  task automatic runProgram();
    int idx;
    for (idx = 0; idx < progQ.size(); idx++) begin
      applyModel(progQ[idx]);
      wbCyc   = 1'b1;
      wbStb   = 1'b1;
      wbWe    = 1'b1;
      wbDatIn = progQ[idx];
      do @(negedge clk); while (!wbAck);
      @(posedge clk);
      #driveDelay;
      ackCycles.push_back(cycleCount);
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic drainAndCompare();
    int waited;
    int n;
    int k;
    waited = 0;
    while (gotDat.size() < expDat.size() && waited < 200) begin
      @(posedge clk);
      waited++;
    end
    repeat (8) @(posedge clk);  // room for any extra result to show up
    #driveDelay;
    checkValue("result count", expDat.size(), gotDat.size());
    n = (expDat.size() < gotDat.size()) ? expDat.size() : gotDat.size();
    for (k = 0; k < n; k++) begin
      checkValue("resAdr", expAdr[k], gotAdr[k]);
      checkValue("resDat", expDat[k], gotDat[k]);
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("%s: ok", name);
    end else begin
      failedTests++;
      $display("%s: %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  task automatic testResetState();
    int errorsBefore;
    errorsBefore = errorCount;
    clearQueues();
    @(negedge clk);
    checkValue("wbAck", 0, wbAck);
    checkValue("resCyc", 0, resCyc);
    checkValue("resStb", 0, resStb);
    repeat (5) begin
      @(negedge clk);
      checkValue("resCyc", 0, resCyc);
      checkValue("resStb", 0, resStb);
    end
    checkValue("result count", 0, gotDat.size());
    @(posedge clk);
    #driveDelay;
    reportTest("reset state", errorsBefore);
  endtask

  task automatic testBasicOps();
    int errorsBefore;
    int i;
    errorsBefore = errorCount;
    clearQueues();
    ackDelayMax = 0;
    for (i = 0; i < `WISC_REG_COUNT; i++) begin
      progQ.push_back(makeLbi(3'(i), 8'(i * 37 + 3)));
    end
    progQ.push_back(makeRType(`WISC_RFUNC_ADD, 3'd3, 3'd1, 3'd2));
    progQ.push_back(makeRType(`WISC_RFUNC_SUB, 3'd4, 3'd5, 3'd6));
    progQ.push_back(makeRType(`WISC_RFUNC_XOR, 3'd5, 3'd7, 3'd4));
    progQ.push_back(makeRType(`WISC_RFUNC_ANDN, 3'd6, 3'd2, 3'd7));
    progQ.push_back(makeImm(`WISC_OP_ADDI, 3'd7, 3'd4, 5'h13));
    progQ.push_back(makeImm(`WISC_OP_ANDNI, 3'd0, 3'd5, 5'h0f));
    runProgram();
    drainAndCompare();
    if (startCycles.size() > 0) begin
      checkValue("first resStb latency", expLatency, startCycles[0] - ackCycles[0]);
    end
    reportTest("basic instructions", errorsBefore);
  endtask

  // each one reads the previous destination, acks are delayed so stalls happen
  task automatic testDependentChain();
    int errorsBefore;
    errorsBefore = errorCount;
    clearQueues();
    ackDelayMax = 3;
    progQ.push_back(makeRType(`WISC_RFUNC_ADD, 3'd1, 3'd0, 3'd2));
    progQ.push_back(makeImm(`WISC_OP_ADDI, 3'd2, 3'd1, 5'h03));
    progQ.push_back(makeRType(`WISC_RFUNC_SUB, 3'd3, 3'd1, 3'd2));
    progQ.push_back(makeRType(`WISC_RFUNC_XOR, 3'd4, 3'd3, 3'd5));
    progQ.push_back(makeRType(`WISC_RFUNC_ANDN, 3'd5, 3'd6, 3'd4));
    progQ.push_back(makeImm(`WISC_OP_ANDNI, 3'd6, 3'd5, 5'h0c));
    progQ.push_back(makeRType(`WISC_RFUNC_ADD, 3'd7, 3'd6, 3'd6));
    progQ.push_back(makeRType(`WISC_RFUNC_SUB, 3'd0, 3'd1, 3'd7));
    progQ.push_back(makeLbi(3'd1, 8'h80));
    progQ.push_back(makeImm(`WISC_OP_ADDI, 3'd1, 3'd1, 5'h1f));
    runProgram();
    drainAndCompare();
    reportTest("dependent chain", errorsBefore);
  endtask

  task automatic testNopInterleave();
    int errorsBefore;
    errorsBefore = errorCount;
    clearQueues();
    ackDelayMax = 0;
    progQ.push_back(makeLbi(3'd2, 8'h5a));
    progQ.push_back(`WISC_NOP_INSTR);
    progQ.push_back(makeRType(`WISC_RFUNC_ADD, 3'd3, 3'd2, 3'd2));
    progQ.push_back(16'ha9e5);  // opcode 10101
    progQ.push_back(`WISC_NOP_INSTR);
    progQ.push_back(makeImm(`WISC_OP_ADDI, 3'd4, 3'd3, 5'h07));
    progQ.push_back(16'h0123);
    progQ.push_back(16'h7fff);
    progQ.push_back(makeRType(`WISC_RFUNC_XOR, 3'd5, 3'd4, 3'd2));
    runProgram();
    drainAndCompare();
    reportTest("nop and unknown opcodes", errorsBefore);
  endtask

  task automatic testRandomProgram();
    int          errorsBefore;
    int          i;
    int          kind;
    logic [31:0] rnd;
    errorsBefore = errorCount;
    clearQueues();
    ackDelayMax = 3;
    for (i = 0; i < 40; i++) begin
      kind = int'(lcgNext() >> 16) % 7;
      rnd  = lcgNext();
      if (kind < 4) begin  // function field value equals kind
        progQ.push_back(makeRType(2'(kind), rnd[18:16], rnd[21:19], rnd[24:22]));
      end else if (kind == 4) begin
        progQ.push_back(makeImm(`WISC_OP_ADDI, rnd[18:16], rnd[21:19], rnd[29:25]));
      end else if (kind == 5) begin
        progQ.push_back(makeImm(`WISC_OP_ANDNI, rnd[18:16], rnd[21:19], rnd[29:25]));
      end else begin
        progQ.push_back(makeLbi(rnd[18:16], rnd[31:24]));
      end
    end
    runProgram();
    drainAndCompare();
    reportTest("random program", errorsBefore);
  endtask

  initial begin
    rstN    = 1'b0;
    wbCyc   = 1'b0;
    wbStb   = 1'b0;
    wbWe    = 1'b0;
    wbDatIn = '0;
    resAck  = 1'b0;
    repeat (2) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;
    testResetState();
    testBasicOps();
    testDependentChain();
    testNopInterleave();
    testRandomProgram();
    $display("tests run %0d, tests failed %0d, errors %0d", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: src/wiscIdExTop.sv
module wiscIdExTop (
  input  logic                clk,
  input  logic                rstN,
  input  logic                wbCyc,
  input  logic                wbStb,
  input  logic                wbWe,
  input  wiscIsaPkg::word_t   wbDatIn,
  output logic                wbAck,
  output logic                resCyc,
  output logic                resStb,
  output logic                resWe,
  output wiscIsaPkg::regIdx_t resAdr,
  output wiscIsaPkg::word_t   resDat,
  input  logic                resAck
);

  logic                     slotValid;
  logic                     slotTake;
  wiscIsaPkg::word_t        slotInstr;
  logic                     hazardStall;
  logic                     pipeFreeze;
  wiscPipePkg::idExBundle_t idExD;
  wiscPipePkg::idExBundle_t idExQ;
  wiscPipePkg::writeBack_t  writeBack;

  instrIntake uIntake (
    .clk, .rstN,
    .wbCyc, .wbStb, .wbWe, .wbDatIn, .wbAck,
    .slotTake, .slotValid, .slotInstr
  );

  decodeStage uDecode (
    .clk, .rstN,
    .slotValid, .slotInstr, .slotTake,
    .idExQ, .writeBack, .pipeFreeze,
    .hazardStall, .idExD
  );

  idExLatch uIdEx (
    .clk, .rstN,
    .en    (!pipeFreeze),
    .stall (hazardStall),
    .idExD, .idExQ
  );

  executeStage uExecute (
    .idExQ, .writeBack
  );

  resultPort uResult (
    .clk, .rstN,
    .writeBack, .pipeFreeze,
    .resCyc, .resStb, .resWe, .resAdr, .resDat, .resAck
  );

endmodule

// File: src/resultPort.sv
module resultPort (
  input  logic                    clk,
  input  logic                    rstN,
  input  wiscPipePkg::writeBack_t writeBack,
  output logic                    pipeFreeze,
  output logic                    resCyc,
  output logic                    resStb,
  output logic                    resWe,
  output wiscIsaPkg::regIdx_t     resAdr,
  output wiscIsaPkg::word_t       resDat,
  input  logic                    resAck
);

  typedef enum logic {
    IDLE,
    BUSY
  } portState_t;

  portState_t state;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (writeBack.valid) state <= BUSY;
        BUSY:    if (resAck) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // capture happens only in IDLE since BUSY with a waiting result freezes everything
  always_ff @(posedge clk) begin
    if (state == IDLE && writeBack.valid) begin
      resAdr <= writeBack.dest;
      resDat <= writeBack.value;
    end
  end

  assign resCyc = (state == BUSY);
  assign resStb = (state == BUSY);
  assign resWe  = (state == BUSY);  // every cycle on this bus is a write

  assign pipeFreeze = (state == BUSY) && writeBack.valid;

  stbHeldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
    $fell(resStb) |-> $past(resAck));

endmodule

// File: src/executeStage.sv
module executeStage (
  input  wiscPipePkg::idExBundle_t idExQ,
  output wiscPipePkg::writeBack_t  writeBack
);

  wiscIsaPkg::word_t imm;
  wiscIsaPkg::word_t opA;
  wiscIsaPkg::word_t opB;
  wiscIsaPkg::word_t aluA;
  wiscIsaPkg::word_t aluB;
  wiscIsaPkg::word_t result;

  always_comb begin
    case (idExQ.ctrl.seSel)
      `WISC_SESEL_Z5: imm = idExQ.z5;
      `WISC_SESEL_S8: imm = idExQ.s8;
      default:        imm = idExQ.s5;
    endcase
  end

  assign opA = idExQ.a;
  assign opB = idExQ.ctrl.aluSrc2 ? imm : idExQ.b;

  assign aluA = idExQ.ctrl.invA ? ~opA : opA;
  assign aluB = idExQ.ctrl.invB ? ~opB : opB;

  always_comb begin
    case (idExQ.ctrl.aluFunc)
      `WISC_ALU_XOR: result = aluA ^ aluB;
      `WISC_ALU_AND: result = aluA & aluB;
      default:       result = aluA + aluB + {15'b0, idExQ.ctrl.cin};
    endcase
  end

  // bubbles and NOPs come out with valid low
  assign writeBack.valid = idExQ.ctrl.regWrite;
  assign writeBack.dest  = wiscPipePkg::destOf(idExQ);
  assign writeBack.value = result;

endmodule

// File: src/idExLatch.sv
module idExLatch (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     en,
  input  logic                     stall,
  input  wiscPipePkg::idExBundle_t idExD,
  output wiscPipePkg::idExBundle_t idExQ
);

  wiscPipePkg::idExBundle_t nextQ;

  // a stalled instruction enters execute as a NOP that writes nothing
  always_comb begin
    nextQ = idExD;
    if (stall) begin
      nextQ.instr         = `WISC_NOP_INSTR;
      nextQ.ctrl.regWrite = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      idExQ       <= '0;
      idExQ.instr <= `WISC_NOP_INSTR;
    end else if (en) begin
      idExQ <= nextQ;
    end
  end

  // neither a bubble nor a decoded NOP may leave ID/EX as a writer
  bubbleWritesNothing: assert property (@(posedge clk) disable iff (!rstN)
    (idExQ.instr == `WISC_NOP_INSTR) |-> !idExQ.ctrl.regWrite);

endmodule

// File: src/decodeStage.sv
module decodeStage (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     slotValid,
  input  wiscIsaPkg::word_t        slotInstr,
  output logic                     slotTake,
  input  wiscPipePkg::idExBundle_t idExQ,
  input  wiscPipePkg::writeBack_t  writeBack,
  input  logic                     pipeFreeze,
  output logic                     hazardStall,
  output wiscPipePkg::idExBundle_t idExD
);

  wiscIsaPkg::word_t   regs [`WISC_REG_COUNT];
  wiscIsaPkg::word_t   instr;
  wiscIsaPkg::opcode_t opcode;
  wiscIsaPkg::rFunc_t  func;
  wiscIsaPkg::regIdx_t rs;
  wiscIsaPkg::regIdx_t rt;
  wiscIsaPkg::regIdx_t idExDest;
  wiscPipePkg::decodeCtrl_t ctrl;
  logic regWe;
  logic readsRs;
  logic readsRt;

  // an empty slot decodes as NOP
  assign instr  = slotValid ? slotInstr : `WISC_NOP_INSTR;
  assign opcode = instr[15:11];
  assign func   = instr[1:0];
  assign rs     = instr[10:8];
  assign rt     = instr[7:5];

  assign regWe = rstN && writeBack.valid && !pipeFreeze;

  always_ff @(posedge clk) begin
    if (regWe) regs[writeBack.dest] <= writeBack.value;
  end

  // write-before-read bypass so the value written on this edge is the one read
  function automatic wiscIsaPkg::word_t readReg(wiscIsaPkg::regIdx_t idx);
    if (writeBack.valid && writeBack.dest == idx) return writeBack.value;
    return regs[idx];
  endfunction

  always_comb begin
    ctrl = '0;
    case (opcode)
      `WISC_OP_RTYPE: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = `WISC_REGDST_RD;
        case (func)
          `WISC_RFUNC_SUB: begin  // rt - rs as ~rs + rt + 1
            ctrl.invA = 1'b1;
            ctrl.cin  = 1'b1;
          end
          `WISC_RFUNC_XOR:  ctrl.aluFunc = `WISC_ALU_XOR;
          `WISC_RFUNC_ANDN: begin
            ctrl.invB    = 1'b1;
            ctrl.aluFunc = `WISC_ALU_AND;
          end
          default: ctrl.aluFunc = `WISC_ALU_ADD;
        endcase
      end
      `WISC_OP_ADDI: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = `WISC_REGDST_RT;
        ctrl.seSel    = `WISC_SESEL_S5;
        ctrl.aluSrc2  = 1'b1;
      end
      `WISC_OP_ANDNI: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = `WISC_REGDST_RT;
        ctrl.seSel    = `WISC_SESEL_Z5;
        ctrl.aluSrc2  = 1'b1;
        ctrl.invB     = 1'b1;
        ctrl.aluFunc  = `WISC_ALU_AND;
      end
      `WISC_OP_LBI: begin  // zero plus the byte immediate
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = `WISC_REGDST_RS;
        ctrl.seSel    = `WISC_SESEL_S8;
        ctrl.aluSrc2  = 1'b1;
      end
      default: ctrl = '0;  // NOP and unknown opcodes
    endcase
  end

  assign readsRt = (opcode == `WISC_OP_RTYPE);
  assign readsRs = readsRt || (opcode == `WISC_OP_ADDI) || (opcode == `WISC_OP_ANDNI);

  // RAW hazard against the instruction in ID/EX resolves only by stalling
  assign idExDest    = wiscPipePkg::destOf(idExQ);
  assign hazardStall = slotValid && idExQ.ctrl.regWrite &&
                       ((readsRs && idExDest == rs) || (readsRt && idExDest == rt));
  assign slotTake    = slotValid && !hazardStall && !pipeFreeze;

  always_comb begin
    idExD.ctrl  = ctrl;
    idExD.a     = (opcode == `WISC_OP_LBI) ? '0 : readReg(rs);
    idExD.b     = readReg(rt);
    idExD.s5    = {{11{instr[4]}}, instr[4:0]};
    idExD.z5    = {11'b0, instr[4:0]};
    idExD.s8    = {{8{instr[7]}}, instr[7:0]};
    idExD.instr = instr;
    idExD.rs    = rs;
    idExD.rt    = rt;
    idExD.rd    = instr[4:2];
  end

  // a write-back held off by the freeze stays presented until the register file takes it
  frozenWriteBackHeld: assert property (@(posedge clk) disable iff (!rstN)
    (pipeFreeze && writeBack.valid) |=> (writeBack.valid && $stable(writeBack)));

endmodule

// File: src/instrIntake.sv
module instrIntake (
  input  logic              clk,
  input  logic              rstN,
  input  logic              wbCyc,
  input  logic              wbStb,
  input  logic              wbWe,
  input  wiscIsaPkg::word_t wbDatIn,
  output logic              wbAck,
  input  logic              slotTake,
  output logic              slotValid,
  output wiscIsaPkg::word_t slotInstr
);

  logic ackQ;     // ack was given last cycle
  logic canLoad;
  logic accept;

  // the slot frees up in the same cycle its instruction moves into ID/EX
  assign canLoad = !slotValid || slotTake;

  // reads are acked too but never touch the slot
  assign wbAck  = wbCyc && wbStb && !ackQ && (!wbWe || canLoad);
  assign accept = wbAck && wbWe;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ackQ      <= 1'b0;
      slotValid <= 1'b0;
    end else begin
      ackQ <= wbAck;
      if (accept) begin
        slotValid <= 1'b1;
      end else if (slotTake) begin
        slotValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) slotInstr <= wbDatIn;
  end

  ackSinglePulse: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck);

endmodule

// File: src/wiscPipePkg.sv
`include "wiscPipe_cfg.svh"

package wiscPipePkg;

  typedef struct packed {
    logic                regWrite;
    logic [1:0]          regDst;   // which instruction field names the destination
    logic [2:0]          seSel;
    logic                aluSrc2;  // second operand is the immediate
    logic                invA;
    logic                invB;
    logic                cin;
    wiscIsaPkg::aluFunc_t aluFunc;
  } decodeCtrl_t;

  typedef struct packed {
    decodeCtrl_t       ctrl;
    wiscIsaPkg::word_t a;
    wiscIsaPkg::word_t b;
    wiscIsaPkg::word_t s5;
    wiscIsaPkg::word_t z5;
    wiscIsaPkg::word_t s8;
    wiscIsaPkg::word_t instr;
    wiscIsaPkg::regIdx_t rs;
    wiscIsaPkg::regIdx_t rt;
    wiscIsaPkg::regIdx_t rd;
  } idExBundle_t;

  typedef struct packed {
    logic                valid;
    wiscIsaPkg::regIdx_t dest;
    wiscIsaPkg::word_t   value;
  } writeBack_t;

  // destination register of the instruction held in ID/EX
  function automatic wiscIsaPkg::regIdx_t destOf(idExBundle_t q);
    case (q.ctrl.regDst)
      `WISC_REGDST_RT: return q.rt;
      `WISC_REGDST_RS: return q.rs;
      default:         return q.rd;
    endcase
  endfunction

endpackage

// File: src/wiscIsaPkg.sv
`include "wiscPipe_cfg.svh"

package wiscIsaPkg;

  // one data or instruction word
  typedef logic [`WISC_WORD_W-1:0] word_t;

  typedef logic [$clog2(`WISC_REG_COUNT)-1:0] regIdx_t;

  typedef logic [4:0] opcode_t;  // instruction bits 15..11

  // add, xor or and, the inversions and carry-in make the rest
  typedef logic [1:0] aluFunc_t;

  typedef logic [1:0] rFunc_t;  // instruction bits 1..0 of an R-type op

endpackage

// File: include/wiscPipe_cfg.svh
`ifndef WISC_PIPE_CFG_SVH
`define WISC_PIPE_CFG_SVH

`define WISC_WORD_W     16
`define WISC_REG_COUNT  8
`define WISC_NOP_INSTR  16'b0000_1000_0000_0000

// opcode field values, bits 15..11
`define WISC_OP_NOP     5'b00001
`define WISC_OP_ADDI    5'b01000
`define WISC_OP_ANDNI   5'b01011
`define WISC_OP_LBI     5'b11000
`define WISC_OP_RTYPE   5'b11011

// R-type function field, bits 1..0
`define WISC_RFUNC_ADD  2'b00
`define WISC_RFUNC_SUB  2'b01
`define WISC_RFUNC_XOR  2'b10
`define WISC_RFUNC_ANDN 2'b11

`define WISC_ALU_ADD    2'b00
`define WISC_ALU_XOR    2'b01
`define WISC_ALU_AND    2'b10

`define WISC_REGDST_RD  2'b00
`define WISC_REGDST_RT  2'b01
`define WISC_REGDST_RS  2'b10

// one-hot immediate select
`define WISC_SESEL_S5   3'b001
`define WISC_SESEL_Z5   3'b010
`define WISC_SESEL_S8   3'b100

`endif
